/* logic/axi_pkg.sv */
// AXI protocol types
package axi_pkg;

    localparam int DATA_BYTES = 8;  // Bytes per beat at full width

    // Byte address
    typedef logic [31:0] addr_t;

    // Beat payload and lane enables
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;

    // Burst length minus one
    typedef logic [7:0] len_t;

    // log2 of bytes per beat
    typedef logic [2:0] size_t;

    // Burst type, reserved code handled like FIXED
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

endpackage

/* logic/mem_pkg.sv */
// RAM geometry
package mem_pkg;

    localparam int WORDS       = 256;
    localparam int OFFSET_BITS = 3;    // Byte within a 64-bit word

    // Word select, address bits 10:3
    typedef logic [7:0] word_idx_t;

endpackage

/* logic/burst_if.sv */
// Burst descriptor link
`timescale 1ns/1ns

interface burst_if;

    axi_pkg::addr_t  start_addr;  // Unaligned address from AxADDR
    axi_pkg::size_t  size;
    axi_pkg::len_t   len;
    axi_pkg::burst_e burst;
    logic            load;        // Capture descriptor
    logic            step;        // Advance one beat

    axi_pkg::addr_t  addr;        // Current beat address
    logic            last;        // Current beat is the final one

    modport ctrl (
        output start_addr, size, len, burst, load, step,
        input  addr, last
    );

    modport gen (
        input  start_addr, size, len, burst, load, step,
        output addr, last
    );

endinterface

/* logic/burst_addr_gen.sv */
// Burst address generator
`timescale 1ns/1ns

module burst_addr_gen (
    input logic clk,
    input logic rst,
    burst_if.gen bus
);

    axi_pkg::addr_t  beat_bytes_in;
    axi_pkg::addr_t  total_bytes_in;

    axi_pkg::addr_t  beat_bytes;
    axi_pkg::addr_t  cur_addr;
    axi_pkg::addr_t  lower_bound;
    axi_pkg::addr_t  upper_bound;
    axi_pkg::addr_t  next_addr;
    axi_pkg::len_t   len_q;
    axi_pkg::len_t   count;
    axi_pkg::burst_e burst_q;

    assign beat_bytes_in  = axi_pkg::addr_t'(1) << bus.size;
    assign total_bytes_in = (axi_pkg::addr_t'(bus.len) + axi_pkg::addr_t'(1)) << bus.size;

    assign next_addr = cur_addr + beat_bytes;

    always_ff @(posedge clk) begin
        if (rst) begin
            count   <= '0;
            burst_q <= axi_pkg::BURST_FIXED;
        end else if (bus.load) begin
            count   <= '0;
            burst_q <= bus.burst;
        end else if (bus.step) begin
            count   <= count + 8'd1;
        end
    end

    // Address datapath
    always_ff @(posedge clk) begin
        if (bus.load) begin
            beat_bytes  <= beat_bytes_in;
            cur_addr    <= bus.start_addr & ~(beat_bytes_in - 1);
            lower_bound <= bus.start_addr & ~(total_bytes_in - 1);  // Only meaningful for WRAP
            upper_bound <= (bus.start_addr & ~(total_bytes_in - 1)) + total_bytes_in;
            len_q       <= bus.len;
        end else if (bus.step) begin
            case (burst_q)
                axi_pkg::BURST_INCR: cur_addr <= next_addr;
                axi_pkg::BURST_WRAP: begin
                    if (next_addr == upper_bound) begin
                        cur_addr <= lower_bound;
                    end else begin
                        cur_addr <= next_addr;
                    end
                end
                default: cur_addr <= cur_addr;  // FIXED and reserved
            endcase
        end
    end

    assign bus.addr = cur_addr;
    assign bus.last = (count == len_q);

endmodule

/* logic/axi_write_channel.sv */
// AXI write channel controller
`timescale 1ns/1ns

module axi_write_channel (
    input  logic                clk,
    input  logic                rst,

    input  axi_pkg::addr_t      awaddr,
    input  axi_pkg::len_t       awlen,
    input  axi_pkg::size_t      awsize,
    input  axi_pkg::burst_e     awburst,
    input  logic                awvalid,
    output logic                awready,

    input  axi_pkg::data_t      wdata,
    input  axi_pkg::strb_t      wstrb,
    input  logic                wvalid,
    output logic                wready,

    output logic                bvalid,
    input  logic                bready,

    output logic                wr_en,
    output mem_pkg::word_idx_t  wr_idx,
    output axi_pkg::data_t      wr_data,
    output axi_pkg::strb_t      wr_strb,

    burst_if.ctrl               burst
);

    typedef enum logic [1:0] {
        W_ADDR,
        W_DATA,
        W_RESP
    } write_state_e;

    write_state_e state;

    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign awready = (state == W_ADDR);
    assign wready  = (state == W_DATA);
    assign bvalid  = (state == W_RESP);

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign b_hs  = bvalid & bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= W_ADDR;
        end else begin
            case (state)
                W_ADDR: if (aw_hs) state <= W_DATA;
                W_DATA: if (w_hs && burst.last) state <= W_RESP;  // WLAST ignored
                W_RESP: if (b_hs) state <= W_ADDR;
                default: state <= W_ADDR;
            endcase
        end
    end

    // Descriptor straight from AW
    assign burst.start_addr = awaddr;
    assign burst.size       = awsize;
    assign burst.len        = awlen;
    assign burst.burst      = awburst;
    assign burst.load       = aw_hs;
    assign burst.step       = w_hs & ~burst.last;

    // Beat goes to RAM on the handshake edge
    assign wr_en   = w_hs;
    assign wr_idx  = mem_pkg::word_idx_t'(burst.addr >> mem_pkg::OFFSET_BITS);
    assign wr_data = wdata;
    assign wr_strb = wstrb;

endmodule

/* logic/burst_ram.sv */
// Byte-strobed dual-port RAM
`timescale 1ns/1ns

module burst_ram (
    input  logic                clk,

    input  logic                wr_en,
    input  mem_pkg::word_idx_t  wr_idx,
    input  axi_pkg::data_t      wr_data,
    input  axi_pkg::strb_t      wr_strb,

    input  logic                rd_en,
    input  mem_pkg::word_idx_t  rd_idx,
    output axi_pkg::data_t      rd_data
);

    axi_pkg::data_t mem [mem_pkg::WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < axi_pkg::DATA_BYTES; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // Registered read, old data on collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

/* logic/axi_read_channel.sv */
// AXI read channel controller
`timescale 1ns/1ns

module axi_read_channel (
    input  logic                clk,
    input  logic                rst,

    input  axi_pkg::addr_t      araddr,
    input  axi_pkg::len_t       arlen,
    input  axi_pkg::size_t      arsize,
    input  axi_pkg::burst_e     arburst,
    input  logic                arvalid,
    output logic                arready,

    output axi_pkg::data_t      rdata,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready,

    output logic                rd_en,
    output mem_pkg::word_idx_t  rd_idx,
    input  axi_pkg::data_t      rd_data,

    burst_if.ctrl               burst
);

    typedef enum logic [1:0] {
        R_ADDR,
        R_FETCH,
        R_WAIT,
        R_BEAT
    } read_state_e;

    read_state_e    state;
    axi_pkg::data_t rdata_q;

    logic ar_hs;
    logic r_hs;

    assign arready = (state == R_ADDR);
    assign rvalid  = (state == R_BEAT);
    assign rlast   = rvalid & burst.last;  // Generator holds still during the beat

    assign ar_hs = arvalid & arready;
    assign r_hs  = rvalid & rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= R_ADDR;
        end else begin
            case (state)
                R_ADDR:  if (ar_hs) state <= R_FETCH;
                R_FETCH: state <= R_WAIT;
                R_WAIT:  state <= R_BEAT;
                R_BEAT: begin
                    if (r_hs) begin
                        state <= burst.last ? R_ADDR : R_FETCH;
                    end
                end
                default: state <= R_ADDR;
            endcase
        end
    end

    // Beat data register, loaded once RAM output settles
    always_ff @(posedge clk) begin
        if (state == R_WAIT) begin
            rdata_q <= rd_data;
        end
    end

    assign rdata = rdata_q;

    assign burst.start_addr = araddr;
    assign burst.size       = arsize;
    assign burst.len        = arlen;
    assign burst.burst      = arburst;
    assign burst.load       = ar_hs;
    assign burst.step       = r_hs & ~burst.last;

    assign rd_en  = (state == R_FETCH);
    assign rd_idx = mem_pkg::word_idx_t'(burst.addr >> mem_pkg::OFFSET_BITS);

endmodule

/* logic/axi_burst_slave.sv */
// AXI4 burst slave with on-chip RAM
`timescale 1ns/1ns

module axi_burst_slave (
    input  logic             clk,
    input  logic             rst,

    input  axi_pkg::addr_t   awaddr,
    input  axi_pkg::len_t    awlen,
    input  axi_pkg::size_t   awsize,
    input  axi_pkg::burst_e  awburst,
    input  logic             awvalid,
    output logic             awready,

    input  axi_pkg::data_t   wdata,
    input  axi_pkg::strb_t   wstrb,
    input  logic             wvalid,
    output logic             wready,

    output logic             bvalid,
    input  logic             bready,

    input  axi_pkg::addr_t   araddr,
    input  axi_pkg::len_t    arlen,
    input  axi_pkg::size_t   arsize,
    input  axi_pkg::burst_e  arburst,
    input  logic             arvalid,
    output logic             arready,

    output axi_pkg::data_t   rdata,
    output logic             rlast,
    output logic             rvalid,
    input  logic             rready
);

    logic               wr_en;
    mem_pkg::word_idx_t wr_idx;
    axi_pkg::data_t     wr_data;
    axi_pkg::strb_t     wr_strb;

    logic               rd_en;
    mem_pkg::word_idx_t rd_idx;
    axi_pkg::data_t     rd_data;

    burst_if wr_burst ();
    burst_if rd_burst ();

    burst_addr_gen u_wr_gen (
        .clk (clk),
        .rst (rst),
        .bus (wr_burst.gen)
    );

    burst_addr_gen u_rd_gen (
        .clk (clk),
        .rst (rst),
        .bus (rd_burst.gen)
    );

    axi_write_channel u_write (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .burst   (wr_burst.ctrl)
    );

    burst_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    axi_read_channel u_read (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_data (rd_data),
        .burst   (rd_burst.ctrl)
    );

endmodule

/* tb/axi_master_tasks.svh */
// AXI master tasks and RAM model
`ifndef AXI_MASTER_TASKS_SVH
`define AXI_MASTER_TASKS_SVH

logic [31:0] rng_state = 32'd56604;
logic [7:0]  model_mem [2048];   // Byte image, aliases modulo 2 KiB

function automatic logic [15:0] rand16();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[30:15];  // Low LCG bits repeat too soon
endfunction

function automatic axi_pkg::data_t rand64();
    return {rand16(), rand16(), rand16(), rand16()};
endfunction

// Byte address of beat n
function automatic axi_pkg::addr_t model_addr(axi_pkg::addr_t start, axi_pkg::size_t size,
        axi_pkg::len_t len, axi_pkg::burst_e burst, int n);
    int unsigned    bytes;
    int unsigned    total;
    axi_pkg::addr_t aligned;
    axi_pkg::addr_t lower;
    bytes   = 1 << size;
    total   = (len + 1) * bytes;
    aligned = start - (start % bytes);
    lower   = start - (start % total);
    case (burst)
        axi_pkg::BURST_INCR: return aligned + n * bytes;
        axi_pkg::BURST_WRAP: return lower + (aligned - lower + n * bytes) % total;
        default:             return aligned;
    endcase
endfunction

function automatic axi_pkg::data_t model_word(axi_pkg::addr_t addr);
    axi_pkg::data_t word;
    for (int i = 0; i < 8; i++) begin
        word[8*i +: 8] = model_mem[{addr[10:3], 3'(i)}];
    end
    return word;
endfunction

// Lanes covered by a narrow beat
function automatic axi_pkg::strb_t lane_strb(axi_pkg::addr_t addr, axi_pkg::size_t size);
    int unsigned bytes;
    bytes = 1 << size;
    return axi_pkg::strb_t'(((1 << bytes) - 1) << addr[2:0]);
endfunction

// Random descriptor confined to one 1 KiB half
task automatic pick_burst(input bit half, output axi_pkg::addr_t addr,
        output axi_pkg::len_t len, output axi_pkg::size_t size, output axi_pkg::burst_e burst);
    int unsigned max_beats;
    size      = axi_pkg::size_t'(rand16() % 4);
    burst     = axi_pkg::burst_e'(rand16() % 4);
    max_beats = (size == 0) ? 256 : (512 >> size);
    if (burst == axi_pkg::BURST_WRAP) begin
        len = axi_pkg::len_t'((2 << (rand16() % 4)) - 1);
    end else begin
        len = axi_pkg::len_t'(rand16() % max_beats);
    end
    addr       = {rand16(), rand16()};   // Upper bits only alias
    addr[10:9] = {half, 1'b0};
endtask

task automatic write_burst(axi_pkg::addr_t addr, axi_pkg::len_t len, axi_pkg::size_t size,
        axi_pkg::burst_e burst, bit random_strb, bit gaps);
    axi_pkg::addr_t beat_addr;
    axi_pkg::data_t data;
    axi_pkg::strb_t strb;
    int             stall;
    bit             hs;
    @(posedge clk);
    awaddr  <= addr;
    awlen   <= len;
    awsize  <= size;
    awburst <= burst;
    awvalid <= 1'b1;
    do begin
        @(negedge clk);
        hs = awready;
        @(posedge clk);
    end while (!hs);
    awvalid <= 1'b0;
    for (int n = 0; n <= len; n++) begin
        beat_addr = model_addr(addr, size, len, burst, n);
        data      = rand64();
        strb      = random_strb ? axi_pkg::strb_t'(rand16()) : lane_strb(beat_addr, size);
        stall     = gaps ? rand16() % 3 : 0;
        wvalid <= 1'b0;
        repeat (stall) @(posedge clk);
        wdata  <= data;
        wstrb  <= strb;
        wvalid <= 1'b1;
        do begin
            @(negedge clk);
            hs = wready;
            @(posedge clk);
        end while (!hs);
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) begin
                model_mem[{beat_addr[10:3], 3'(i)}] = data[8*i +: 8];
            end
        end
    end
    wvalid <= 1'b0;
    stall = gaps ? rand16() % 4 : 0;
    do @(negedge clk); while (!bvalid);
    repeat (stall) begin
        @(posedge clk);
        @(negedge clk);
        expect_value("BVALID under back-pressure", 1, bvalid);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    expect_value("BVALID", 1, bvalid);
    @(posedge clk);   // B handshake
    bready <= 1'b0;
    writes_issued++;
    @(negedge clk);
    expect_value("BVALID after B handshake", 0, bvalid);
    expect_value("B handshake count", writes_issued, b_count);
endtask

task automatic read_burst(axi_pkg::addr_t addr, axi_pkg::len_t len, axi_pkg::size_t size,
        axi_pkg::burst_e burst, bit gaps);
    axi_pkg::data_t expected;
    axi_pkg::data_t held_data;
    logic           held_last;
    int             stall;
    bit             hs;
    @(posedge clk);
    araddr  <= addr;
    arlen   <= len;
    arsize  <= size;
    arburst <= burst;
    arvalid <= 1'b1;
    do begin
        @(negedge clk);
        hs = arready;
        @(posedge clk);
    end while (!hs);
    arvalid <= 1'b0;
    for (int n = 0; n <= len; n++) begin
        stall = gaps ? rand16() % 4 : 0;
        do @(negedge clk); while (!rvalid);
        held_data = rdata;
        held_last = rlast;
        repeat (stall) begin
            @(posedge clk);
            @(negedge clk);
            expect_value("RVALID under back-pressure", 1, rvalid);
            expect_value("RDATA under back-pressure", held_data, rdata);
            expect_value("RLAST under back-pressure", held_last, rlast);
        end
        expected = model_word(model_addr(addr, size, len, burst, n));
        expect_value($sformatf("RDATA beat %0d", n), expected, rdata);
        expect_value($sformatf("RLAST beat %0d", n), n == len, rlast);
        @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        @(posedge clk);   // R handshake
        rready <= 1'b0;
    end
    @(negedge clk);
    expect_value("RVALID after last beat", 0, rvalid);
endtask

`endif

/* tb/axi_burst_slave_tb.sv */
// AXI burst slave testbench
`timescale 1ns/1ns

module axi_burst_slave_tb;

    localparam int N_INCR  = 8;
    localparam int N_FIXED = 6;   // Last two use the reserved encoding
    localparam int N_MIX   = 24;
    // Fill, INCR pairs, 4 WRAP writes with 30 single reads, FIXED pairs, mix pairs
    localparam int NUM_BURSTS     = 1 + 2 * N_INCR + 4 + 30 + 2 * N_FIXED + 2 * N_MIX;
    localparam int TIMEOUT_CYCLES = NUM_BURSTS * 257 * 6 + 100;

    logic            clk;
    logic            rst;
    axi_pkg::addr_t  awaddr;
    axi_pkg::len_t   awlen;
    axi_pkg::size_t  awsize;
    axi_pkg::burst_e awburst;
    logic            awvalid;
    logic            awready;
    axi_pkg::data_t  wdata;
    axi_pkg::strb_t  wstrb;
    logic            wvalid;
    logic            wready;
    logic            bvalid;
    logic            bready;
    axi_pkg::addr_t  araddr;
    axi_pkg::len_t   arlen;
    axi_pkg::size_t  arsize;
    axi_pkg::burst_e arburst;
    logic            arvalid;
    logic            arready;
    axi_pkg::data_t  rdata;
    logic            rlast;
    logic            rvalid;
    logic            rready;

    string test_name;
    int    cycles;
    int    writes_issued;
    int    b_count;         // BVALID assertions seen on the bus
    bit    bvalid_prev;

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic expect_value(string what, logic [63:0] expected, logic [63:0] actual);
        assert (actual === expected)
            else report_failure($sformatf("Error %s: %s expected %h actual %h",
                                          test_name, what, expected, actual));
    endtask

    `include "axi_master_tasks.svh"

    axi_burst_slave UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < TIMEOUT_CYCLES)
            else report_failure($sformatf("Timeout, run went past %0d cycles", TIMEOUT_CYCLES));
    end

    // A write burst must raise BVALID exactly once
    always @(negedge clk) begin
        if (bvalid && !bvalid_prev) begin
            b_count++;
        end
        bvalid_prev = bvalid;
    end

    initial begin
        axi_pkg::addr_t  addr;
        axi_pkg::addr_t  waddr;
        axi_pkg::addr_t  raddr;
        axi_pkg::len_t   len;
        axi_pkg::len_t   wlen;
        axi_pkg::len_t   rlen;
        axi_pkg::size_t  size;
        axi_pkg::size_t  wsize;
        axi_pkg::size_t  rsize;
        axi_pkg::burst_e burst;
        axi_pkg::burst_e wburst;
        axi_pkg::burst_e rburst;
        bit              half;

        rst     = 1'b1;
        awaddr  = '0;
        awlen   = '0;
        awsize  = '0;
        awburst = axi_pkg::BURST_FIXED;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = axi_pkg::BURST_FIXED;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset";
        @(negedge clk);
        expect_value("AWREADY", 1, awready);
        expect_value("ARREADY", 1, arready);
        expect_value("WREADY", 0, wready);
        expect_value("BVALID", 0, bvalid);
        expect_value("RVALID", 0, rvalid);
        expect_value("RLAST", 0, rlast);

        test_name = "fill";  // Every word gets known data
        write_burst(32'h0, 8'd255, 3'd3, axi_pkg::BURST_INCR, 1'b0, 1'b0);

        test_name = "incr";
        repeat (N_INCR) begin
            size = axi_pkg::size_t'(rand16() % 4);
            len  = axi_pkg::len_t'(rand16());
            addr = {rand16(), rand16()} & ~((32'd1 << size) - 1);
            write_burst(addr, len, size, axi_pkg::BURST_INCR, 1'b0, 1'b0);
            read_burst(addr, len, size, axi_pkg::BURST_INCR, 1'b0);
        end

        test_name = "wrap";
        for (int k = 0; k < 4; k++) begin
            len  = axi_pkg::len_t'((2 << k) - 1);
            size = axi_pkg::size_t'(rand16() % 4);
            addr = {rand16(), rand16()} & ~(((32'(len) + 1) << size) - 1);
            addr = addr + (((rand16() % len) + 1) << size);  // Start mid-block
            write_burst(addr, len, size, axi_pkg::BURST_WRAP, 1'b0, 1'b0);
            for (int n = 0; n <= len; n++) begin
                read_burst(model_addr(addr, size, len, axi_pkg::BURST_WRAP, n),
                           8'd0, 3'd3, axi_pkg::BURST_INCR, 1'b0);
            end
        end

        for (int k = 0; k < N_FIXED; k++) begin
            test_name = (k < N_FIXED - 2) ? "fixed" : "reserved";
            burst = (k < N_FIXED - 2) ? axi_pkg::BURST_FIXED : axi_pkg::BURST_RSVD;
            len   = axi_pkg::len_t'(rand16() % 16);
            size  = axi_pkg::size_t'(rand16() % 4);
            addr  = {rand16(), rand16()};
            write_burst(addr, len, size, burst, 1'b1, 1'b0);
            read_burst(addr, len, size, burst, 1'b0);
        end

        test_name = "mix";
        repeat (N_MIX) begin
            half = rand16() % 2;
            pick_burst(half, waddr, wlen, wsize, wburst);
            pick_burst(!half, raddr, rlen, rsize, rburst);
            fork
                write_burst(waddr, wlen, wsize, wburst, 1'b1, 1'b1);
                read_burst(raddr, rlen, rsize, rburst, 1'b1);
            join
        end
        expect_value("B handshakes", writes_issued, b_count);

        $display("Test OK");
        $finish;
    end

endmodule

/* axi_burst_slave.f */
+incdir+tb
logic/axi_pkg.sv
logic/mem_pkg.sv
logic/burst_if.sv
logic/burst_addr_gen.sv
logic/axi_write_channel.sv
logic/burst_ram.sv
logic/axi_read_channel.sv
logic/axi_burst_slave.sv
tb/axi_burst_slave_tb.sv

/* Bender.yml */
package:
  name: axi_burst_slave

sources:
  - logic/axi_pkg.sv
  - logic/mem_pkg.sv
  - logic/burst_if.sv
  - logic/burst_addr_gen.sv
  - logic/axi_write_channel.sv
  - logic/burst_ram.sv
  - logic/axi_read_channel.sv
  - logic/axi_burst_slave.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/axi_burst_slave_tb.sv
